//--- logic/vp_pkg.sv
/* Shared widths, bus records and download indices for the console glue logic.
   Pad and joystick records keep the bit layout of the host gamepad words. */
package vp_pkg;

	localparam int CART_AW   = 12;  // Console cartridge address
	localparam int DL_AW     = 14;  // Download address, covers a 16K image
	localparam int CART_SZ_W = 16;

	localparam logic [7:0] DL_IDX_XROM = 8'd2;

	// Image sizes that select a banked mapping
	localparam logic [CART_SZ_W-1:0] CART_4K  = 16'h1000;
	localparam logic [CART_SZ_W-1:0] CART_8K  = 16'h2000;
	localparam logic [CART_SZ_W-1:0] CART_16K = 16'h4000;

	typedef struct packed {
		logic             active;
		logic             wr;
		logic [7:0]       index;
		logic [DL_AW-1:0] addr;
		logic [7:0]       data;
	} dl_req_t;

	typedef struct packed {
		logic [CART_AW-1:0] addr;
		logic               bs0;
		logic               bs1;
		logic               cs_n;
		logic               psen_n;
	} cart_bus_t;

	// Keys 1 to 9 in numpad[8:0], key 0 in numpad[9]
	typedef struct packed {
		logic [9:0] numpad;
		logic       reset;
		logic       action;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} pad_t;

	// Active low, index 1 is the left player
	typedef struct packed {
		logic [1:0] up;
		logic [1:0] down;
		logic [1:0] left;
		logic [1:0] right;
		logic [1:0] action;
		logic       reset_n;
	} joy_lines_t;

	typedef struct packed {
		logic [7:0] ascii;
		logic       released;
	} key_evt_t;

endpackage

//--- logic/vp_clk_enables.sv
/* CPU and VDC clock-enable pulses, one cycle wide.
   A change of pal_i restarts both dividers, as the console restarts on a standard change. */
`timescale 1ns/10ps

module vp_clk_enables (
	input  logic clk_sys,
	input  logic reset,
	input  logic pal_i,
	output logic cpu_en_o,
	output logic vdc_en_o
);

	logic [1:0][3:0] div_ctr;  // [0] CPU, [1] VDC
	logic [1:0][3:0] wrap_at;
	logic [1:0]      en_q;
	logic            pal_q;

	assign wrap_at[0] = pal_i ? 4'd11 : 4'd7;  // Divide by 12 or 8
	assign wrap_at[1] = pal_i ? 4'd9 : 4'd5;   // Divide by 10 or 6

	assign cpu_en_o = en_q[0];
	assign vdc_en_o = en_q[1];

	// Follows the setting during reset as well
	always_ff @(posedge clk_sys) begin
		pal_q <= pal_i;
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			div_ctr <= '0;
			en_q    <= '0;
		end else if (pal_i != pal_q) begin
			div_ctr <= '0;  // Standard changed, restart
			en_q    <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (div_ctr[i] >= wrap_at[i]) begin
					div_ctr[i] <= 4'd0;
					en_q[i]    <= 1'b1;
				end else begin
					div_ctr[i] <= div_ctr[i] + 4'd1;
					en_q[i]    <= 1'b0;
				end
			end
		end
	end

endmodule

//--- logic/vp_cart_loader.sv
/* Measures each download and maps the console cartridge bus onto the ROM.
   Image sizes other than 4K, 8K and 16K fall back to the unbanked 2K+2K layout. */
`timescale 1ns/10ps

module vp_cart_loader import vp_pkg::*; #(
	parameter int ROM_AW = 14
) (
	input  logic              clk_sys,
	input  logic              reset,
	input  dl_req_t           dl_i,
	input  cart_bus_t         cart_i,
	output logic [ROM_AW-1:0] rom_addr_o,
	output logic              rom_rd_o
);

	logic                 active_q;
	logic                 xrom;       // Current image is an external ROM
	logic [CART_SZ_W-1:0] cart_size;
	logic [CART_AW+1:0]   map_addr;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			active_q  <= 1'b0;
			xrom      <= 1'b0;
			cart_size <= '0;
		end else begin
			active_q <= dl_i.active;
			if (dl_i.active && !active_q) begin
				cart_size <= '0;  // New download
				xrom      <= (dl_i.index == DL_IDX_XROM);
			end else if (dl_i.active && dl_i.wr) begin
				cart_size <= cart_size + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Cartridge address mapping

	// A10 only reaches the ROM in the 16K layout
	always_comb begin
		if (xrom) begin
			map_addr = {2'b00, cart_i.addr};
		end else begin
			case (cart_size)
				CART_4K:  map_addr = {2'b00, cart_i.bs0, cart_i.addr[11], cart_i.addr[9:0]};
				CART_8K:  map_addr = {1'b0, cart_i.bs1, cart_i.bs0, cart_i.addr[11],
					cart_i.addr[9:0]};
				CART_16K: map_addr = {cart_i.bs1, cart_i.bs0, cart_i.addr};
				default:  map_addr = {3'b000, cart_i.addr[11], cart_i.addr[9:0]};
			endcase
		end
	end

	assign rom_addr_o = ROM_AW'(map_addr);

	// External ROM answers outside the bank-0 cartridge window
	assign rom_rd_o = xrom ? ((~cart_i.bs0 | cart_i.cs_n) & ~cart_i.psen_n) : ~cart_i.psen_n;

endmodule

//--- logic/vp_cart_rom.sv
/* Single-port cartridge ROM, written by the download and read by the console.
   A download write takes the port, so no read happens in that cycle. */
`timescale 1ns/10ps

module vp_cart_rom import vp_pkg::*; #(
	parameter int ROM_AW = 14
) (
	input  logic              clk_sys,
	input  dl_req_t           dl_i,
	input  logic [ROM_AW-1:0] rd_addr_i,
	input  logic              rd_en_i,
	output logic [7:0]        data_o
);

	logic [7:0] mem [2**ROM_AW];
	logic       wr_en;

	assign wr_en = dl_i.wr && (dl_i.index < 8'd3);  // Indices 0 to 2 are ROM images

	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			mem[ROM_AW'(dl_i.addr)] <= dl_i.data;
		end else if (rd_en_i) begin
			data_o <= mem[rd_addr_i];  // Holds until the next read
		end
	end

endmodule

//--- logic/vp_key_encoder.sv
/* PS/2 set 2 scan codes and number-pad keys to ASCII key events.
   One output slot, events that arrive while it is full are lost. */
`timescale 1ns/10ps

module vp_key_encoder import vp_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [10:0] ps2_key_i,
	input  logic [9:0]  numpad_i,
	input  logic        numpad_chg_i,
	input  logic        key_ready_i,
	output logic        key_valid_o,
	output key_evt_t    key_evt_o
);

	// Make codes for "0" to "9" and "a" to "z"
	localparam logic [7:0] DIGIT_SC [10] = '{8'h45, 8'h16, 8'h1e, 8'h26, 8'h25,
		8'h2e, 8'h36, 8'h3d, 8'h3e, 8'h46};
	localparam logic [7:0] LETTER_SC [26] = '{8'h1c, 8'h32, 8'h21, 8'h23, 8'h24,
		8'h2b, 8'h34, 8'h33, 8'h43, 8'h3b, 8'h42, 8'h4b, 8'h3a, 8'h31, 8'h44,
		8'h4d, 8'h15, 8'h2d, 8'h1b, 8'h2c, 8'h3c, 8'h2a, 8'h1d, 8'h22, 8'h35, 8'h1a};

	function automatic logic [7:0] scan_to_ascii(input logic [7:0] sc);
		logic [7:0] asc;
		case (sc)
			8'h29:   asc = " ";
			8'h79:   asc = "+";
			8'h7b:   asc = "-";
			8'h7c:   asc = "*";
			8'h4a:   asc = "/";
			8'h55:   asc = "=";
			8'h1f:   asc = 8'h11;  // Left GUI, yes
			8'h27:   asc = 8'h12;  // Right GUI, no
			8'h5a:   asc = 8'd10;  // Enter
			8'h66:   asc = 8'd8;   // Backspace
			default: asc = 8'h00;
		endcase
		for (int i = 0; i < 10; i++)
			if (sc == DIGIT_SC[i])
				asc = 8'h30 + 8'(i);
		for (int i = 0; i < 26; i++)
			if (sc == LETTER_SC[i])
				asc = 8'h61 + 8'(i);
		return asc;
	endfunction

	// Lowest pressed key wins
	function automatic logic [7:0] pad_to_ascii(input logic [9:0] pad);
		logic [7:0] asc;
		asc = 8'h00;
		for (int i = 9; i >= 0; i--)
			if (pad[i])
				asc = (i == 9) ? 8'h30 : 8'h31 + 8'(i);
		return asc;
	endfunction

	logic       strb_q;
	logic       ps2_tgl;
	logic       ps2_chg, ps2_rel;
	logic       pad_chg, pad_rel;
	logic [7:0] ps2_ascii, pad_ascii;
	logic       evt_pend, slot_free;

	assign ps2_tgl = ps2_key_i[10] ^ strb_q;

	////////////////////////////////////////////////////////////////////////////
	// Stage 1, detect and translate

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			strb_q  <= 1'b0;
			ps2_chg <= 1'b0;
			ps2_rel <= 1'b1;
			pad_chg <= 1'b0;
			pad_rel <= 1'b1;
		end else begin
			strb_q  <= ps2_key_i[10];
			ps2_chg <= ps2_tgl;
			ps2_rel <= ~ps2_key_i[9];
			pad_chg <= numpad_chg_i;
			pad_rel <= (numpad_i == '0);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ps2_tgl)
			ps2_ascii <= scan_to_ascii(ps2_key_i[7:0]);
		if (numpad_i != '0)
			pad_ascii <= pad_to_ascii(numpad_i);  // Kept for the release event
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage 2, output slot

	assign evt_pend  = ps2_chg | pad_chg;
	assign slot_free = ~key_valid_o | key_ready_i;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			key_valid_o <= 1'b0;
		else if (evt_pend && slot_free)
			key_valid_o <= 1'b1;
		else if (key_ready_i)
			key_valid_o <= 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (evt_pend && slot_free) begin
			key_evt_o.ascii    <= ps2_chg ? ps2_ascii : pad_ascii;  // PS/2 first
			key_evt_o.released <= ps2_rel & pad_rel;
		end
	end

endmodule

//--- logic/vp_input_ctrl.sv
/* Gamepad routing to the console joystick lines and keyboard events.
   Both number pads merge into one, so the same key on two pads is one key. */
`timescale 1ns/10ps

module vp_input_ctrl import vp_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  pad_t        pad_a_i,
	input  pad_t        pad_b_i,
	input  logic        joy_swap_i,
	input  logic [10:0] ps2_key_i,
	input  logic        key_ready_i,
	output joy_lines_t  joy_o,
	output logic        key_valid_o,
	output key_evt_t    key_evt_o
);

	pad_t       pad_l, pad_r;   // After the swap
	logic [9:0] numpad, numpad_q;
	logic       numpad_chg;

	assign pad_l = joy_swap_i ? pad_b_i : pad_a_i;
	assign pad_r = joy_swap_i ? pad_a_i : pad_b_i;

	// Lines are low when pressed
	always_comb begin
		joy_o.up      = ~{pad_l.up, pad_r.up};
		joy_o.down    = ~{pad_l.down, pad_r.down};
		joy_o.left    = ~{pad_l.left, pad_r.left};
		joy_o.right   = ~{pad_l.right, pad_r.right};
		joy_o.action  = ~{pad_l.action, pad_r.action};
		joy_o.reset_n = ~(pad_l.reset & pad_r.reset);  // Needs both pads
	end

	assign numpad = pad_a_i.numpad | pad_b_i.numpad;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			numpad_q <= '0;
		else
			numpad_q <= numpad;
	end

	assign numpad_chg = (numpad != numpad_q);

	vp_key_encoder u_key_encoder (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.ps2_key_i    (ps2_key_i),
		.numpad_i     (numpad),
		.numpad_chg_i (numpad_chg),
		.key_ready_i  (key_ready_i),
		.key_valid_o  (key_valid_o),
		.key_evt_o    (key_evt_o)
	);

endmodule

//--- logic/vp_palette.sv
/* Console colour index {R, G, B, luma} to 24-bit RGB, NTSC or PAL table.
   The output only moves on the VDC enable. */
`timescale 1ns/10ps

module vp_palette (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        vdc_en_i,
	input  logic        pal_palette_i,
	input  logic [3:0]  color_idx_i,
	output logic [23:0] rgb_o
);

	// Calibrated NTSC set, pairs of dark and luma entries
	localparam logic [23:0] LUT_NTSC [16] = '{
		24'h000000, 24'h676767, 24'h1a37be, 24'h5c80f6,  // Black, blue
		24'h006d07, 24'h56c469, 24'h2aaabe, 24'h77e6eb,  // Green, cyan
		24'h790000, 24'hc75151, 24'h94309f, 24'hdc84e8,  // Red, magenta
		24'h77670b, 24'hc6b86a, 24'hcecece, 24'hffffff   // Yellow, white
	};

	localparam logic [23:0] LUT_PAL [16] = '{
		24'h000000, 24'h494949, 24'h0000b6, 24'h4949ff,
		24'h00b601, 24'h49ff49, 24'h00b6c9, 24'h49ffff,
		24'hb60000, 24'hff4949, 24'hb600b6, 24'hff49ff,
		24'hb6b600, 24'hffff49, 24'hb6b6b6, 24'hffffff
	};

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			rgb_o <= 24'h000000;
		else if (vdc_en_i)
			rgb_o <= pal_palette_i ? LUT_PAL[color_idx_i] : LUT_NTSC[color_idx_i];
	end

endmodule

//--- logic/vp_host.sv
/* Glue around the console CPU and VDC: enables, cartridge ROM, inputs and palette.
   The CPU and VDC themselves sit outside and attach through these ports. */
`timescale 1ns/10ps

module vp_host import vp_pkg::*; #(
	parameter int ROM_AW = 14
) (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        pal_i,
	input  logic        pal_palette_i,
	input  logic        joy_swap_i,
	input  dl_req_t     dl_i,
	input  cart_bus_t   cart_i,
	input  pad_t        pad_a_i,
	input  pad_t        pad_b_i,
	input  logic [10:0] ps2_key_i,
	input  logic [3:0]  color_idx_i,
	input  logic        key_ready_i,
	output logic        cpu_en_o,
	output logic        vdc_en_o,
	output logic [7:0]  cart_data_o,
	output joy_lines_t  joy_o,
	output logic        key_valid_o,
	output key_evt_t    key_evt_o,
	output logic [23:0] rgb_o
);

	logic [ROM_AW-1:0] rom_addr;
	logic              rom_rd;

	vp_clk_enables u_clk_enables (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.pal_i    (pal_i),
		.cpu_en_o (cpu_en_o),
		.vdc_en_o (vdc_en_o)
	);

	////////////////////////////////////////////////////////////////////////////
	// Cartridge

	vp_cart_loader #(.ROM_AW(ROM_AW)) u_cart_loader (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_i       (dl_i),
		.cart_i     (cart_i),
		.rom_addr_o (rom_addr),
		.rom_rd_o   (rom_rd)
	);

	vp_cart_rom #(.ROM_AW(ROM_AW)) u_cart_rom (
		.clk_sys   (clk_sys),
		.dl_i      (dl_i),
		.rd_addr_i (rom_addr),
		.rd_en_i   (rom_rd),
		.data_o    (cart_data_o)
	);

	////////////////////////////////////////////////////////////////////////////
	// Inputs and video

	vp_input_ctrl u_input_ctrl (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.pad_a_i     (pad_a_i),
		.pad_b_i     (pad_b_i),
		.joy_swap_i  (joy_swap_i),
		.ps2_key_i   (ps2_key_i),
		.key_ready_i (key_ready_i),
		.joy_o       (joy_o),
		.key_valid_o (key_valid_o),
		.key_evt_o   (key_evt_o)
	);

	vp_palette u_palette (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.vdc_en_i      (vdc_en_o),
		.pal_palette_i (pal_palette_i),
		.color_idx_i   (color_idx_i),
		.rgb_o         (rgb_o)
	);

endmodule

//--- tb/vp_host_chk.sv
/* Concurrent checks bound to the top level, active outside reset only. */
`timescale 1ns/10ps

module vp_host_chk import vp_pkg::*; (
	input logic     clk_sys,
	input logic     reset,
	input logic     cpu_en_o,
	input logic     vdc_en_o,
	input logic     key_valid_o,
	input logic     key_ready_i,
	input key_evt_t key_evt_o
);

	a_cpu_en_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_en_o |=> !cpu_en_o) else $error("cpu_en_o stayed high for two cycles");

	a_vdc_en_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		vdc_en_o |=> !vdc_en_o) else $error("vdc_en_o stayed high for two cycles");

	// Slot holds until the transfer
	a_evt_stable: assert property (@(posedge clk_sys) disable iff (reset)
		key_valid_o && !key_ready_i |=> $stable(key_evt_o))
		else $error("key_evt_o changed while stalled");

	a_valid_hold: assert property (@(posedge clk_sys) disable iff (reset)
		key_valid_o && !key_ready_i |=> key_valid_o)
		else $error("key_valid_o fell without a transfer");

endmodule

bind vp_host vp_host_chk u_chk (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.cpu_en_o    (cpu_en_o),
	.vdc_en_o    (vdc_en_o),
	.key_valid_o (key_valid_o),
	.key_ready_i (key_ready_i),
	.key_evt_o   (key_evt_o)
);

//--- tb/tb_vp_host.sv
/* Directed testbench for the console glue top level.
   Inputs change on the falling edge. ROM bytes and ready stalls come from a seeded $urandom. */
`timescale 1ns/10ps

module tb_vp_host import vp_pkg::*; ();

	localparam int CLK_PERIOD  = 20;
	localparam int ROM_AW      = 14;
	localparam int TEST_CYCLES = 4096 + 16384 + 4096 + 1024;  // Three downloads plus the rest
	localparam int WATCHDOG_NS = (TEST_CYCLES + TEST_CYCLES / 4) * CLK_PERIOD;
	localparam int MAP_4K      = 0;
	localparam int MAP_16K     = 1;
	localparam int MAP_XROM    = 2;

	localparam logic [8:0]  KEY_SC [4]    = '{9'h016, 9'h01c, 9'h05a, 9'h076};
	localparam logic [7:0]  KEY_ASCII [4] = '{8'h31, 8'h61, 8'h0a, 8'h00};  // 1, a, Enter, none
	localparam logic [3:0]  COL_IDX [3]   = '{4'd0, 4'd9, 4'd15};
	localparam logic [23:0] RGB_NTSC [3]  = '{24'h000000, 24'hc75151, 24'hffffff};
	localparam logic [23:0] RGB_PAL [3]   = '{24'h000000, 24'hff4949, 24'hffffff};

	logic        clk_sys, reset;
	logic        pal_i, pal_palette_i, joy_swap_i, key_ready_i;
	dl_req_t     dl_i;
	cart_bus_t   cart_i;
	pad_t        pad_a_i, pad_b_i;
	logic [10:0] ps2_key_i;
	logic [3:0]  color_idx_i;
	logic        cpu_en_o, vdc_en_o, key_valid_o;
	logic [7:0]  cart_data_o;
	joy_lines_t  joy_o;
	key_evt_t    key_evt_o;
	logic [23:0] rgb_o;

	logic [7:0] exp_mem [2**ROM_AW];  // Model of the ROM contents
	int         errors, checks;

	vp_host #(.ROM_AW(ROM_AW)) u_dut (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.pal_i         (pal_i),
		.pal_palette_i (pal_palette_i),
		.joy_swap_i    (joy_swap_i),
		.dl_i          (dl_i),
		.cart_i        (cart_i),
		.pad_a_i       (pad_a_i),
		.pad_b_i       (pad_b_i),
		.ps2_key_i     (ps2_key_i),
		.color_idx_i   (color_idx_i),
		.key_ready_i   (key_ready_i),
		.cpu_en_o      (cpu_en_o),
		.vdc_en_o      (vdc_en_o),
		.cart_data_o   (cart_data_o),
		.joy_o         (joy_o),
		.key_valid_o   (key_valid_o),
		.key_evt_o     (key_evt_o),
		.rgb_o         (rgb_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	// Cycles between two pulses of one enable
	task automatic pulse_gap(input logic use_vdc, output int gap);
		int n;
		n = 0;
		while (!(use_vdc ? vdc_en_o : cpu_en_o) && n < 32) begin
			@(negedge clk_sys);
			n++;
		end
		gap = 0;
		do begin
			@(negedge clk_sys);
			gap++;
		end while (!(use_vdc ? vdc_en_o : cpu_en_o) && gap < 32);
	endtask

	task automatic load_image(input logic [7:0] idx, input int nbytes);
		dl_i = '0;
		dl_i.active = 1'b1;  // First cycle without a write starts the size count
		dl_i.index  = idx;
		for (int a = 0; a < nbytes; a++) begin
			@(negedge clk_sys);
			dl_i.wr   = 1'b1;
			dl_i.addr = DL_AW'(a);
			dl_i.data = 8'($urandom);
			if (idx < 8'd3)
				exp_mem[a] = dl_i.data;
		end
		@(negedge clk_sys);
		dl_i = '0;
		@(negedge clk_sys);
	endtask

	// ROM address the console request should reach
	function automatic logic [ROM_AW-1:0] cart_addr(input int kind, input cart_bus_t c);
		case (kind)
			MAP_4K:  return {2'b00, c.bs0, c.addr[11], c.addr[9:0]};
			MAP_16K: return {c.bs1, c.bs0, c.addr};
			default: return {2'b00, c.addr};
		endcase
	endfunction

	task automatic read_back(input int kind, input logic bs1, input logic bs0, input int n);
		logic [7:0] exp;
		for (int i = 0; i < n; i++) begin
			cart_i.addr   = CART_AW'($urandom);
			cart_i.bs0    = bs0;
			cart_i.bs1    = bs1;
			cart_i.cs_n   = 1'b1;
			cart_i.psen_n = 1'b0;
			exp = exp_mem[cart_addr(kind, cart_i)];
			@(negedge clk_sys);
			check_eq("cart_data_o", cart_data_o, exp);
		end
		cart_i.psen_n = 1'b1;
	endtask

	task automatic send_scan(input logic [8:0] code, input logic pressed);
		ps2_key_i = {~ps2_key_i[10], pressed, code};
	endtask

	task automatic await_valid(output int lat);
		lat = 0;
		do begin
			@(negedge clk_sys);
			lat++;
		end while (!key_valid_o && lat < 20);
		assert (key_valid_o) else begin
			errors++;
			$display("Key event never became valid within 20 cycles at %0t", $time);
		end
	endtask

	// Random stall with ready low, then one transfer cycle
	task automatic take_event(output key_evt_t evt);
		int stall;
		evt   = key_evt_o;
		stall = $urandom % 6;
		repeat (stall) begin
			@(negedge clk_sys);
			check_eq("key_valid_o", key_valid_o, 1);
			check_eq("key_evt_o", key_evt_o, evt);
		end
		key_ready_i = 1'b1;
		@(negedge clk_sys);
		key_ready_i = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests

	task automatic enable_periods();
		int gap;
		pulse_gap(1'b0, gap);
		check_eq("cpu_en_o period", gap, 8);
		pulse_gap(1'b1, gap);
		check_eq("vdc_en_o period", gap, 6);
		pal_i = 1'b1;
		@(negedge clk_sys);
		pulse_gap(1'b0, gap);
		check_eq("cpu_en_o period", gap, 12);
		pulse_gap(1'b1, gap);
		check_eq("vdc_en_o period", gap, 10);
		// Nine CPU and five VDC cycles after the last pulses, so without a
		// restart both NTSC enables would fire right after the switch back
		repeat (5) @(negedge clk_sys);
		pal_i = 1'b0;
		@(negedge clk_sys);
		check_eq("cpu_en_o", cpu_en_o, 0);
		check_eq("vdc_en_o", vdc_en_o, 0);
	endtask

	task automatic cart_4k_mapping();
		load_image(8'd0, 4096);
		read_back(MAP_4K, 1'b0, 1'b0, 64);
		read_back(MAP_4K, 1'b0, 1'b1, 64);
	endtask

	task automatic cart_16k_and_xrom();
		load_image(8'd0, 16384);
		for (int b = 0; b < 4; b++)
			read_back(MAP_16K, b[1], b[0], 64);
		load_image(DL_IDX_XROM, 4096);
		read_back(MAP_XROM, 1'b0, 1'b0, 64);
	endtask

	task automatic key_backpressure();
		key_evt_t evt;
		int       lat;
		for (int i = 0; i < 4; i++) begin
			send_scan(KEY_SC[i], 1'b1);
			await_valid(lat);
			check_eq("key_valid_o latency", lat, 2);
			take_event(evt);
			check_eq("key_evt_o.ascii", evt.ascii, KEY_ASCII[i]);
			check_eq("key_evt_o.released", evt.released, 0);
		end
		// A second key while the slot is full is lost
		send_scan(KEY_SC[0], 1'b1);
		await_valid(lat);
		send_scan(KEY_SC[1], 1'b1);
		repeat (3) @(negedge clk_sys);
		take_event(evt);
		check_eq("key_evt_o.ascii", evt.ascii, KEY_ASCII[0]);
		repeat (4) begin
			@(negedge clk_sys);
			check_eq("key_valid_o", key_valid_o, 0);
		end
		send_scan(KEY_SC[1], 1'b0);
		await_valid(lat);
		take_event(evt);
		check_eq("key_evt_o.ascii", evt.ascii, KEY_ASCII[1]);
		check_eq("key_evt_o.released", evt.released, 1);
	endtask

	task automatic numpad_keys();
		key_evt_t evt;
		int       lat;
		pad_a_i.numpad = 10'b00_0100_0100;  // Keys 3 and 7
		await_valid(lat);
		take_event(evt);
		check_eq("key_evt_o.ascii", evt.ascii, 8'h33);
		check_eq("key_evt_o.released", evt.released, 0);
		pad_a_i.numpad = '0;
		await_valid(lat);
		take_event(evt);
		check_eq("key_evt_o.released", evt.released, 1);
	endtask

	task automatic joy_and_palette();
		joy_lines_t exp;
		int         n;
		pad_a_i.up   = 1'b1;
		pad_b_i.left = 1'b1;
		exp = '1;
		exp.up   = 2'b01;
		exp.left = 2'b10;
		@(posedge clk_sys);
		check_eq("joy_o", joy_o, exp);
		@(negedge clk_sys);
		joy_swap_i = 1'b1;
		exp.up     = 2'b10;
		exp.left   = 2'b01;
		@(posedge clk_sys);
		check_eq("joy_o", joy_o, exp);
		@(negedge clk_sys);
		pad_a_i.reset = 1'b1;
		@(posedge clk_sys);
		check_eq("joy_o.reset_n", joy_o.reset_n, 1);
		@(negedge clk_sys);
		pad_b_i.reset = 1'b1;
		@(posedge clk_sys);
		check_eq("joy_o.reset_n", joy_o.reset_n, 0);
		@(negedge clk_sys);
		for (int p = 0; p < 2; p++) begin
			for (int i = 0; i < 3; i++) begin
				pal_palette_i = p[0];
				color_idx_i   = COL_IDX[i];
				n = 0;
				do begin
					@(negedge clk_sys);
					n++;
				end while (!vdc_en_o && n < 16);
				@(negedge clk_sys);
				check_eq("rgb_o", rgb_o, p[0] ? RGB_PAL[i] : RGB_NTSC[i]);
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sequence and watchdog

	initial begin
		void'($urandom(32'h2d63f179));
		errors        = 0;
		checks        = 0;
		reset         = 1'b1;
		pal_i         = 1'b0;
		pal_palette_i = 1'b0;
		joy_swap_i    = 1'b0;
		key_ready_i   = 1'b0;
		dl_i          = '0;
		cart_i        = '0;
		cart_i.cs_n   = 1'b1;
		cart_i.psen_n = 1'b1;
		pad_a_i       = '0;
		pad_b_i       = '0;
		ps2_key_i     = '0;
		color_idx_i   = '0;
		repeat (8) @(negedge clk_sys);
		check_eq("key_valid_o", key_valid_o, 0);
		check_eq("cpu_en_o", cpu_en_o, 0);
		check_eq("vdc_en_o", vdc_en_o, 0);
		check_eq("rgb_o", rgb_o, 0);
		reset = 1'b0;
		enable_periods();
		cart_4k_mapping();
		cart_16k_and_xrom();
		key_backpressure();
		numpad_keys();
		joy_and_palette();
		$display("Checks run %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the tests did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- vp_host.f
logic/vp_pkg.sv
logic/vp_clk_enables.sv
logic/vp_cart_loader.sv
logic/vp_cart_rom.sv
logic/vp_key_encoder.sv
logic/vp_input_ctrl.sv
logic/vp_palette.sv
logic/vp_host.sv
tb/vp_host_chk.sv
tb/tb_vp_host.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for failures
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_vp_host \
	-f vp_host.f -o sim_vp_host > build.log 2>&1 \
	&& ./obj_dir/sim_vp_host > sim.log 2>&1 \
	|| { echo "Build or simulation run did not complete"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qE "TEST FAILED|%Error" sim.log \
	&& { echo "Simulation reported failures"; exit 1; } \
	|| { echo "Simulation clean"; exit 0; }
